// File: build.f
+incdir+logic
logic/rvPkg.sv
logic/hazardIf.sv
logic/alu.sv
logic/regFile.sv
logic/controlUnit.sv
logic/hazardUnit.sv
logic/datapath.sv
logic/riscvCore.sv
dv/coreTb.sv

// File: dv/coreGolden.hex
// word count, then program words, then store count,
// then one store per line as address and data
00000028
10000513 // 00 addi x10, x0, 256
123450B7 // 01 lui  x1, 0x12345
67808093 // 02 addi x1, x1, 0x678
00152023 // 03 sw   x1, 0(x10)
FFB00113 // 04 addi x2, x0, -5
00700193 // 05 addi x3, x0, 7
40310233 // 06 sub  x4, x2, x3
002202B3 // 07 add  x5, x4, x2
00552223 // 08 sw   x5, 4(x10)
00312333 // 09 slt  x6, x2, x3
FFF1A393 // 0a slti x7, x3, -1
FFC12413 // 0b slti x8, x2, -4
00738633 // 0c add  x12, x7, x7
00860633 // 0d add  x12, x12, x8
00C60633 // 0e add  x12, x12, x12
00660633 // 0f add  x12, x12, x6
00C52423 // 10 sw   x12, 8(x10)
0F00F693 // 11 andi x13, x1, 0xf0
7006E713 // 12 ori  x14, x13, 0x700
FFF74793 // 13 xori x15, x14, -1
0017F833 // 14 and  x16, x15, x1
00D848B3 // 15 xor  x17, x16, x13
01152623 // 16 sw   x17, 12(x10)
07B00013 // 17 addi x0, x0, 123
00300933 // 18 add  x18, x0, x3
01252823 // 19 sw   x18, 16(x10)
00452983 // 1a lw   x19, 4(x10)
01498A13 // 1b addi x20, x19, 20
01452A23 // 1c sw   x20, 20(x10)
00218463 // 1d beq  x3, x2, +8 not taken
00100A93 // 1e addi x21, x0, 1
01218663 // 1f beq  x3, x18, +12 taken
00352C23 // 20 sw   x3, 24(x10) skipped
06300A93 // 21 addi x21, x0, 99 skipped
00C00B6F // 22 jal  x22, +12
00352E23 // 23 sw   x3, 28(x10) skipped
04D00A93 // 24 addi x21, x0, 77 skipped
01552C23 // 25 sw   x21, 24(x10)
01652E23 // 26 sw   x22, 28(x10)
0000006F // 27 jal  x0, 0
00000008
00000100 12345678
00000104 FFFFFFEF
00000108 00000003
0000010C 12345078
00000110 00000007
00000114 00000003
00000118 00000001
0000011C 0000008C

// File: dv/coreTb.sv
`timescale 1ns/100ps
`include "rvCfg.svh"

module coreTb;

    logic                clk;
    logic                reset;
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] instr;
    logic                memWrite;
    logic [`RV_XLEN-1:0] dataAddr;
    logic [`RV_XLEN-1:0] writeData;
    logic [`RV_XLEN-1:0] readData;

    logic [31:0] golden [0:255];   // raw words of the golden file
    logic [31:0] imem   [0:255];
    logic [31:0] dmem   [0:255];

    int          progWords;
    int          expStores;
    int          storesSeen;
    int          cycleLimit;
    int          cycles;
    int          selfHits;      // arrivals at the closing self-jump
    logic [31:0] selfAddr;
    logic [31:0] prevPc;

    riscvCore DUT (
        .clk       (clk),
        .reset     (reset),
        .pc        (pc),
        .instr     (instr),
        .memWrite  (memWrite),
        .dataAddr  (dataAddr),
        .writeData (writeData),
        .readData  (readData)
    );

    always #5 clk = ~clk;

    task automatic stopWithError(input string reason);
        $display("%s", reason);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic compareValue(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
        if (actual !== expected)
            stopWithError($sformatf("mismatch on %s: got 0x%h, expected 0x%h",
                                    name, actual, expected));
    endtask

    // program into imem, store list stays in golden
    task automatic loadGolden();
        int i;
        $readmemh("dv/coreGolden.hex", golden);
        progWords = int'(golden[0]);
        if (progWords < 1 || progWords > 200)
            stopWithError("golden file does not give a usable program length");
        for (i = 0; i < 256; i++) begin
            imem[8'(i)] = '0;   // no-op past the program
            dmem[8'(i)] = '0;
        end
        for (i = 0; i < progWords; i++)
            imem[8'(i)] = golden[8'(i + 1)];
        expStores = int'(golden[8'(progWords + 1)]);
        if (progWords + 2 + 2 * expStores > 256)
            stopWithError("golden file lists more stores than it can hold");
        selfAddr   = 32'((progWords - 1) * 4);   // last word jumps to itself
        cycleLimit = 20 * progWords + 50;
    endtask

    // both memories answer combinationally from registered addresses
    task automatic driveMemories();
        instr    = imem[pc[9:2]];
        readData = dmem[dataAddr[9:2]];
    endtask

    task automatic checkStore();
        int base;
        if (storesSeen >= expStores)
            stopWithError($sformatf("store to address 0x%h was not expected", dataAddr));
        base = progWords + 2 + 2 * storesSeen;
        compareValue("dataAddr", dataAddr, golden[8'(base)]);
        compareValue("writeData", writeData, golden[8'(base + 1)]);
        dmem[dataAddr[9:2]] = writeData;
        storesSeen++;
    endtask

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        instr      = '0;
        readData   = '0;
        storesSeen = 0;
        cycles     = 0;
        selfHits   = 0;
        loadGolden();

        // five rising edges in reset
        repeat (5) begin
            @(negedge clk);
            compareValue("memWrite", 32'(memWrite), 32'h0);
            compareValue("pc", pc, `RV_RESET_PC);
        end
        reset  = 1'b0;
        prevPc = '1;
        driveMemories();   // first fetch on the next rising edge

        while (selfHits < 2) begin
            @(negedge clk);
            cycles++;
            if (cycles > cycleLimit)
                stopWithError("program did not reach its final self-jump in time");
            if (memWrite)
                checkStore();
            // second arrival means the jump ran and older stores drained
            if (pc == selfAddr && pc != prevPc)
                selfHits++;
            prevPc = pc;
            driveMemories();
        end

        if (storesSeen != expStores) begin
            stopWithError($sformatf("program made %0d stores, golden file expects %0d",
                                    storesSeen, expStores));
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule

// File: logic/alu.sv
`timescale 1ns/100ps
`include "rvCfg.svh"

module alu (
    input  logic [`RV_XLEN-1:0] srcA,
    input  logic [`RV_XLEN-1:0] srcB,
    input  rvPkg::aluOpT        op,
    output logic [`RV_XLEN-1:0] result,
    output logic                zero
);
    import rvPkg::*;

    logic                subtract;
    logic [`RV_XLEN-1:0] condInvB;
    logic [`RV_XLEN-1:0] carryIn;
    logic [`RV_XLEN-1:0] sum;
    logic                overflow;
    logic                lessThan;

    // slt compares through the same subtractor
    assign subtract = (op == aluSub) || (op == aluSlt);
    assign condInvB = subtract ? ~srcB : srcB;
    assign carryIn  = {{(`RV_XLEN-1){1'b0}}, subtract};
    assign sum      = srcA + condInvB + carryIn;

    // operands agree in sign but the sum does not
    assign overflow = ~(srcA[`RV_XLEN-1] ^ condInvB[`RV_XLEN-1]) &
                      (srcA[`RV_XLEN-1] ^ sum[`RV_XLEN-1]);
    assign lessThan = sum[`RV_XLEN-1] ^ overflow;

    always_comb begin
        case (op)
            aluAnd:  result = srcA & srcB;
            aluOr:   result = srcA | srcB;
            aluXor:  result = srcA ^ srcB;
            aluSlt:  result = {{(`RV_XLEN-1){1'b0}}, lessThan};
            default: result = sum;   // add, sub
        endcase
    end

    assign zero = (result == '0);

endmodule

// File: logic/controlUnit.sv
`timescale 1ns/100ps
`include "rvCfg.svh"

module controlUnit (
    input  logic             clk,
    input  logic             reset,
    input  rvPkg::instrT     instrD,
    input  logic             zeroE,
    input  logic             flushE,
    output rvPkg::immSelT    immSelD,
    output rvPkg::execCtrlT  execCtrlE,
    output logic             pcSrcE,
    output logic             memWriteM,
    output rvPkg::resultSelT resultSelW,
    hazardIf.ctrl            haz
);
    import rvPkg::*;

    logic      regWriteD, memWriteD;
    resultSelT resultSelD;
    execCtrlT  execCtrlD;
    aluOpT     functOpD;
    logic      subBitD;     // funct7[5] only means sub for register ops

    logic      regWriteE, memWriteE;
    resultSelT resultSelE, resultSelM;
    logic      regWriteM, regWriteW;

    assign subBitD = instrD.regView.funct7[5] & (instrD.regView.opcode == `RV_OP_REG);

    // alu op for register and immediate arithmetic
    always_comb begin
        case (instrD.regView.funct3)
            3'b000:  functOpD = subBitD ? aluSub : aluAdd;
            3'b010:  functOpD = aluSlt;
            3'b100:  functOpD = aluXor;
            3'b110:  functOpD = aluOr;
            3'b111:  functOpD = aluAnd;
            default: functOpD = aluAdd;
        endcase
    end

    // main decoder, unknown opcodes fall out as a no-op
    always_comb begin
        regWriteD  = 1'b0;
        memWriteD  = 1'b0;
        resultSelD = aluResult;
        immSelD    = iImm;
        execCtrlD  = '0;
        case (instrD.regView.opcode)
            `RV_OP_LOAD: begin
                regWriteD        = 1'b1;
                resultSelD       = memData;
                execCtrlD.useImm = 1'b1;
            end
            `RV_OP_STORE: begin
                memWriteD        = 1'b1;
                immSelD          = sImm;
                execCtrlD.useImm = 1'b1;
            end
            `RV_OP_REG: begin
                regWriteD       = 1'b1;
                execCtrlD.aluOp = functOpD;
            end
            `RV_OP_IMM: begin
                regWriteD        = 1'b1;
                execCtrlD.useImm = 1'b1;
                execCtrlD.aluOp  = functOpD;
            end
            `RV_OP_BRANCH: begin
                immSelD          = bImm;
                execCtrlD.branch = 1'b1;
                execCtrlD.aluOp  = aluSub;  // equal when difference is zero
            end
            `RV_OP_JAL: begin
                regWriteD      = 1'b1;
                immSelD        = jImm;
                resultSelD     = linkPc;
                execCtrlD.jump = 1'b1;
            end
            `RV_OP_LUI: begin
                regWriteD        = 1'b1;
                immSelD          = uImm;
                execCtrlD.zeroA  = 1'b1;
                execCtrlD.useImm = 1'b1;
            end
            default: ;
        endcase
    end

    // execute stage controls, bubble on flush
    always_ff @(posedge clk or posedge reset) begin
        if (reset || flushE) begin
            regWriteE  <= 1'b0;
            memWriteE  <= 1'b0;
            resultSelE <= aluResult;
            execCtrlE  <= '0;
        end else begin
            regWriteE  <= regWriteD;
            memWriteE  <= memWriteD;
            resultSelE <= resultSelD;
            execCtrlE  <= execCtrlD;
        end
    end

    // memory and writeback controls
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            regWriteM  <= 1'b0;
            memWriteM  <= 1'b0;
            resultSelM <= aluResult;
            regWriteW  <= 1'b0;
            resultSelW <= aluResult;
        end else begin
            regWriteM  <= regWriteE;
            memWriteM  <= memWriteE;
            resultSelM <= resultSelE;
            regWriteW  <= regWriteM;
            resultSelW <= resultSelM;
        end
    end

    assign pcSrcE = (execCtrlE.branch & zeroE) | execCtrlE.jump;

    assign haz.pcSrcE    = pcSrcE;
    assign haz.loadE     = (resultSelE == memData);
    assign haz.regWriteM = regWriteM;
    assign haz.regWriteW = regWriteW;

endmodule

// File: logic/datapath.sv
`timescale 1ns/100ps
`include "rvCfg.svh"

module datapath (
    input  logic                clk,
    input  logic                reset,
    output logic [`RV_XLEN-1:0] pc,
    input  logic [`RV_XLEN-1:0] instr,
    output rvPkg::instrT        instrD,
    input  rvPkg::immSelT       immSelD,
    input  rvPkg::execCtrlT     execCtrlE,
    input  logic                pcSrcE,
    output logic                zeroE,
    output logic [`RV_XLEN-1:0] aluResultM,
    output logic [`RV_XLEN-1:0] writeDataM,
    input  logic [`RV_XLEN-1:0] readDataM,
    input  logic                regWriteW,
    input  rvPkg::resultSelT    resultSelW,
    hazardIf.pipe               haz
);
    import rvPkg::*;

    logic [`RV_XLEN-1:0] pcNextF, pcPlus4F;
    logic [`RV_XLEN-1:0] pcD, pcPlus4D, readDataAD, readDataBD, immExtD;
    logic                immSign;
    logic [`RV_XLEN-1:0] readDataAE, readDataBE, pcE, pcPlus4E, immExtE;
    logic [`RV_XLEN-1:0] srcAFwdE, srcAE, srcBE, writeDataE, aluResultE, pcTargetE;
    logic [`RV_REG_ADDR_W-1:0] rs1E, rs2E, rdE, rdM, rdW;
    logic [`RV_XLEN-1:0] pcPlus4M;
    logic [`RV_XLEN-1:0] aluResultW, readDataW, pcPlus4W, resultW;

    function automatic logic [`RV_XLEN-1:0] forwardMux(
        input forwardSelT          sel,
        input logic [`RV_XLEN-1:0] regVal,
        input logic [`RV_XLEN-1:0] wbVal,
        input logic [`RV_XLEN-1:0] memVal
    );
        case (sel)
            fromMemory:    return memVal;
            fromWriteback: return wbVal;
            default:       return regVal;
        endcase
    endfunction

    // fetch
    assign pcPlus4F = pc + `RV_XLEN'(4);
    assign pcNextF  = pcSrcE ? pcTargetE : pcPlus4F;

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            pc <= `RV_RESET_PC;
        else if (!haz.stallF)
            pc <= pcNextF;
    end

    // decode register, flush wins over stall
    always_ff @(posedge clk or posedge reset) begin
        if (reset || haz.flushD) begin
            instrD   <= '0;
            pcD      <= '0;
            pcPlus4D <= '0;
        end else if (!haz.stallD) begin
            instrD   <= instr;
            pcD      <= pc;
            pcPlus4D <= pcPlus4F;
        end
    end

    regFile regs (
        .clk       (clk),
        .reset     (reset),
        .writeEn   (regWriteW),
        .readAddrA (instrD.regView.rs1),
        .readAddrB (instrD.regView.rs2),
        .writeAddr (rdW),
        .writeData (resultW),
        .readDataA (readDataAD),
        .readDataB (readDataBD)
    );

    assign immSign = instrD.regView.funct7[6];

    always_comb begin
        case (immSelD)
            iImm: immExtD = {{20{immSign}}, instrD.regView.funct7, instrD.regView.rs2};
            sImm: immExtD = {{20{immSign}}, instrD.regView.funct7, instrD.regView.rd};
            bImm: immExtD = {{20{immSign}}, instrD.regView.rd[0], instrD.regView.funct7[5:0],
                             instrD.regView.rd[4:1], 1'b0};
            jImm: immExtD = {{12{immSign}}, instrD.upperView.upperImm[7:0],
                             instrD.upperView.upperImm[8], instrD.upperView.upperImm[18:9], 1'b0};
            uImm: immExtD = {instrD.upperView.upperImm, 12'b0};
            default: immExtD = '0;
        endcase
    end

    // execute register
    always_ff @(posedge clk or posedge reset) begin
        if (reset || haz.flushE) begin
            readDataAE <= '0;
            readDataBE <= '0;
            pcE        <= '0;
            pcPlus4E   <= '0;
            immExtE    <= '0;
            rs1E       <= '0;
            rs2E       <= '0;
            rdE        <= '0;
        end else begin
            readDataAE <= readDataAD;
            readDataBE <= readDataBD;
            pcE        <= pcD;
            pcPlus4E   <= pcPlus4D;
            immExtE    <= immExtD;
            rs1E       <= instrD.regView.rs1;
            rs2E       <= instrD.regView.rs2;
            rdE        <= instrD.regView.rd;
        end
    end

    assign srcAFwdE   = forwardMux(haz.forwardA, readDataAE, resultW, aluResultM);
    assign writeDataE = forwardMux(haz.forwardB, readDataBE, resultW, aluResultM);
    assign srcAE      = execCtrlE.zeroA ? '0 : srcAFwdE;
    assign srcBE      = execCtrlE.useImm ? immExtE : writeDataE;
    assign pcTargetE  = pcE + immExtE;   // beq and jal target

    alu aluE (
        .srcA   (srcAE),
        .srcB   (srcBE),
        .op     (execCtrlE.aluOp),
        .result (aluResultE),
        .zero   (zeroE)
    );

    // memory and writeback registers
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            aluResultM <= '0;
            writeDataM <= '0;
            rdM        <= '0;
            pcPlus4M   <= '0;
            aluResultW <= '0;
            readDataW  <= '0;
            rdW        <= '0;
            pcPlus4W   <= '0;
        end else begin
            aluResultM <= aluResultE;
            writeDataM <= writeDataE;
            rdM        <= rdE;
            pcPlus4M   <= pcPlus4E;
            aluResultW <= aluResultM;
            readDataW  <= readDataM;
            rdW        <= rdM;
            pcPlus4W   <= pcPlus4M;
        end
    end

    always_comb begin
        case (resultSelW)
            memData: resultW = readDataW;
            linkPc:  resultW = pcPlus4W;   // jal link
            default: resultW = aluResultW;
        endcase
    end

    assign haz.rs1D = instrD.regView.rs1;
    assign haz.rs2D = instrD.regView.rs2;
    assign haz.rs1E = rs1E;
    assign haz.rs2E = rs2E;
    assign haz.rdE  = rdE;
    assign haz.rdM  = rdM;
    assign haz.rdW  = rdW;

endmodule

// File: logic/hazardIf.sv
`timescale 1ns/100ps
`include "rvCfg.svh"

interface hazardIf;
    import rvPkg::*;

    logic [`RV_REG_ADDR_W-1:0] rs1D, rs2D;
    logic [`RV_REG_ADDR_W-1:0] rs1E, rs2E;
    logic [`RV_REG_ADDR_W-1:0] rdE, rdM, rdW;
    logic                      loadE;
    logic                      regWriteM, regWriteW;
    logic                      pcSrcE;
    forwardSelT                forwardA, forwardB;
    logic                      stallF, stallD;
    logic                      flushD, flushE;

    modport pipe (output rs1D, rs2D, rs1E, rs2E, rdE, rdM, rdW,
                  input  forwardA, forwardB, stallF, stallD, flushD, flushE);

    modport ctrl (output loadE, regWriteM, regWriteW, pcSrcE);

    modport unit (input  rs1D, rs2D, rs1E, rs2E, rdE, rdM, rdW,
                  input  loadE, regWriteM, regWriteW, pcSrcE,
                  output forwardA, forwardB, stallF, stallD, flushD, flushE);

endinterface

// File: logic/hazardUnit.sv
`timescale 1ns/100ps
`include "rvCfg.svh"

module hazardUnit (
    hazardIf.unit haz
);
    import rvPkg::*;

    logic loadStall;

    // memory stage wins over writeback, x0 never forwarded
    function automatic forwardSelT pickSource(
        input logic [`RV_REG_ADDR_W-1:0] rs,
        input logic [`RV_REG_ADDR_W-1:0] rdM,
        input logic                      regWriteM,
        input logic [`RV_REG_ADDR_W-1:0] rdW,
        input logic                      regWriteW
    );
        if (rs == '0)
            return fromReg;
        if (regWriteM && rs == rdM)
            return fromMemory;
        if (regWriteW && rs == rdW)
            return fromWriteback;
        return fromReg;
    endfunction

    assign haz.forwardA = pickSource(haz.rs1E, haz.rdM, haz.regWriteM, haz.rdW, haz.regWriteW);
    assign haz.forwardB = pickSource(haz.rs2E, haz.rdM, haz.regWriteM, haz.rdW, haz.regWriteW);

    // load result is not ready until writeback
    assign loadStall = haz.loadE & ((haz.rs1D == haz.rdE) | (haz.rs2D == haz.rdE));

    assign haz.stallF = loadStall;
    assign haz.stallD = loadStall;
    assign haz.flushD = haz.pcSrcE;               // drop wrong-path fetch
    assign haz.flushE = loadStall | haz.pcSrcE;   // bubble or wrong-path decode

endmodule

// File: logic/regFile.sv
`timescale 1ns/100ps
`include "rvCfg.svh"

module regFile (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      writeEn,
    input  logic [`RV_REG_ADDR_W-1:0] readAddrA,
    input  logic [`RV_REG_ADDR_W-1:0] readAddrB,
    input  logic [`RV_REG_ADDR_W-1:0] writeAddr,
    input  logic [`RV_XLEN-1:0]       writeData,
    output logic [`RV_XLEN-1:0]       readDataA,
    output logic [`RV_XLEN-1:0]       readDataB
);
    logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];

    // falling edge write, so decode sees it in the same cycle
    always_ff @(negedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `RV_REG_COUNT; i++)
                regs[i] <= '0;
        end else if (writeEn) begin
            regs[writeAddr] <= writeData;
        end
    end

    assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];  // x0 reads zero
    assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

endmodule

// File: logic/riscvCore.sv
`timescale 1ns/100ps
`include "rvCfg.svh"

module riscvCore (
    input  logic                clk,
    input  logic                reset,
    output logic [`RV_XLEN-1:0] pc,
    input  logic [`RV_XLEN-1:0] instr,
    output logic                memWrite,
    output logic [`RV_XLEN-1:0] dataAddr,
    output logic [`RV_XLEN-1:0] writeData,
    input  logic [`RV_XLEN-1:0] readData
);
    import rvPkg::*;

    instrT     instrD;
    immSelT    immSelD;
    execCtrlT  execCtrlE;
    logic      pcSrcE;
    logic      zeroE;
    resultSelT resultSelW;

    hazardIf hazBus ();

    controlUnit control (
        .clk        (clk),
        .reset      (reset),
        .instrD     (instrD),
        .zeroE      (zeroE),
        .flushE     (hazBus.flushE),
        .immSelD    (immSelD),
        .execCtrlE  (execCtrlE),
        .pcSrcE     (pcSrcE),
        .memWriteM  (memWrite),
        .resultSelW (resultSelW),
        .haz        (hazBus)
    );

    datapath dp (
        .clk        (clk),
        .reset      (reset),
        .pc         (pc),
        .instr      (instr),
        .instrD     (instrD),
        .immSelD    (immSelD),
        .execCtrlE  (execCtrlE),
        .pcSrcE     (pcSrcE),
        .zeroE      (zeroE),
        .aluResultM (dataAddr),
        .writeDataM (writeData),
        .readDataM  (readData),
        .regWriteW  (hazBus.regWriteW),
        .resultSelW (resultSelW),
        .haz        (hazBus)
    );

    hazardUnit hazards (
        .haz (hazBus)
    );

endmodule

// File: logic/rvCfg.svh
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// datapath and register file geometry
`define RV_XLEN         32
`define RV_REG_COUNT    32
`define RV_REG_ADDR_W   5

`define RV_RESET_PC     32'h0000_0000  // first fetch after reset

// base opcodes of the supported subset
`define RV_OP_LOAD      7'b0000011  // lw
`define RV_OP_STORE     7'b0100011  // sw
`define RV_OP_REG       7'b0110011  // add sub and or xor slt
`define RV_OP_IMM       7'b0010011  // addi andi ori xori slti
`define RV_OP_BRANCH    7'b1100011  // beq
`define RV_OP_JAL       7'b1101111
`define RV_OP_LUI       7'b0110111

`endif

// File: logic/rvPkg.sv
package rvPkg;

`include "rvCfg.svh"

    // R/I/S/B layout of an instruction word
    typedef struct packed {
        logic [6:0]                funct7;
        logic [`RV_REG_ADDR_W-1:0] rs2;
        logic [`RV_REG_ADDR_W-1:0] rs1;
        logic [2:0]                funct3;
        logic [`RV_REG_ADDR_W-1:0] rd;
        logic [6:0]                opcode;
    } regViewT;

    // U/J layout, lui and jal
    typedef struct packed {
        logic [19:0]               upperImm;
        logic [`RV_REG_ADDR_W-1:0] rd;
        logic [6:0]                opcode;
    } upperViewT;

    typedef union packed {
        regViewT   regView;
        upperViewT upperView;
    } instrT;

    typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt} aluOpT;

    typedef enum logic [2:0] {iImm, sImm, bImm, jImm, uImm} immSelT;

    typedef enum logic [1:0] {aluResult, memData, linkPc} resultSelT;

    typedef enum logic [1:0] {fromReg, fromWriteback, fromMemory} forwardSelT;

    // controls consumed in execute
    typedef struct packed {
        aluOpT aluOp;
        logic  zeroA;   // lui adds the immediate to zero
        logic  useImm;
        logic  branch;
        logic  jump;
    } execCtrlT;

endpackage

// File: runSim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps --top-module coreTb -f build.f

simOut=$(./obj_dir/VcoreTb 2>&1) || true
printf '%s\n' "$simOut"

if printf '%s\n' "$simOut" | grep -qx "All checks passed"; then
    exit 0
fi
exit 1
